/* uart_frame_link.f */
logic/uart_frame_pkg.sv
logic/uart_tx.sv
logic/uart_rx.sv
logic/frame_tx.sv
logic/frame_rx.sv
logic/uart_frame_link.sv
bench/uart_frame_link_tb.sv

/* Makefile */
# Verilator build for the UART frame link testbench

VERILATOR ?= verilator
TOP       ?= uart_frame_link_tb
FLIST     ?= uart_frame_link.f
BUILD_DIR ?= build
VFLAGS    ?= --binary --timing --assert

PASS_MSG  := TESTBENCH PASSED
SIM_BIN   := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)

# pass or fail decided from the simulator output
run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* bench/uart_frame_link_tb.sv */
// UART frame link testbench
// loopback and serial-driven frames checked by concurrent assertions
// against a reference payload and length
`timescale 1ns/1ps
`default_nettype none

module uart_frame_link_tb import uart_frame_pkg::*;;

	localparam int CLK_DIV     = 8;
	localparam int BIT_CYCLES  = 8;
	localparam int FRAME_LIMIT = 40 * 10 * BIT_CYCLES;
	localparam int SETTLE      = 20;
	localparam int WATCHDOG_NS = 6 * 36 * 80 * 4 * 2;

	logic     sys_clk;
	logic     sys_rst_n;
	payload_t tx_string;
	len_t     tx_length;
	logic     tx_req;
	logic     use_loop;
	logic     ser_line;
	wire      uart_rx_port;
	wire      uart_tx_port;
	wire      tx_busy;
	wire      tx_done;
	payload_t rx_string;
	len_t     rx_length;
	wire      rx_busy;
	wire      rx_done;
	wire      rx_error;

	// reference frame and expectations
	payload_t    ref_string;
	len_t        ref_length;
	logic        expect_error;
	logic [15:0] lfsr_state;
	int          errors;
	int          tests_run;
	int          done_cnt;
	int          err_cnt;
	int          tx_done_cnt;

	assign uart_rx_port = use_loop ? uart_tx_port : ser_line;

	uart_frame_link #(.CLK_DIV(CLK_DIV)) u_dut (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.tx_string    (tx_string),
		.tx_length    (tx_length),
		.tx_req       (tx_req),
		.tx_busy      (tx_busy),
		.tx_done      (tx_done),
		.rx_string    (rx_string),
		.rx_length    (rx_length),
		.rx_busy      (rx_busy),
		.rx_done      (rx_done),
		.rx_error     (rx_error),
		.uart_rx_port (uart_rx_port),
		.uart_tx_port (uart_tx_port)
	);

	always #2 sys_clk = ~sys_clk;

	// pulse counters
	always @(posedge sys_clk) begin
		if (rx_done) done_cnt <= done_cnt + 1;
		if (rx_error) err_cnt <= err_cnt + 1;
		if (tx_done) tx_done_cnt <= tx_done_cnt + 1;
	end

	a_busy_rise: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		(tx_req && !tx_busy) |=> tx_busy)
		else begin
			errors++;
			$display("tx_busy did not rise the cycle after tx_req");
		end

	a_tx_done_single: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		tx_done |=> (!tx_done && !tx_busy))
		else begin
			errors++;
			$display("tx_done was not a single pulse followed by tx_busy low");
		end

	a_busy_fall: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		$fell(tx_busy) |-> $past(tx_done))
		else begin
			errors++;
			$display("tx_busy fell without tx_done on the cycle before");
		end

	// receiver busy ends exactly with the done or error pulse
	a_rx_busy_end: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		$fell(rx_busy) == (rx_done || rx_error))
		else begin
			errors++;
			$display("rx_busy did not fall together with rx_done or rx_error");
		end

	a_done_string: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		(rx_done || rx_error) |-> rx_string == ref_string)
		else begin
			errors++;
			$display("Fail rx_string: got %h, expected %h",
				$sampled(rx_string), ref_string);
		end

	a_done_length: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		(rx_done || rx_error) |-> rx_length == ref_length)
		else begin
			errors++;
			$display("Fail rx_length: got %h, expected %h",
				$sampled(rx_length), ref_length);
		end

	a_done_wanted: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		rx_done |-> !expect_error)
		else begin
			errors++;
			$display("rx_done pulsed for a frame that should have been dropped");
		end

	a_error_wanted: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		rx_error |-> expect_error)
		else begin
			errors++;
			$display("rx_error pulsed where no error was expected");
		end

	// Galois LFSR with taps x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		logic [15:0] n;
		n = s >> 1;
		if (s[0]) n = n ^ 16'hB400;
		return n;
	endfunction

	// one LFSR step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr_state[0]};
			lfsr_state = lfsr_next(lfsr_state);
		end
		return v;
	endfunction

	function automatic byte_t rand_plain_byte();
		logic [31:0] r;
		r = rand_bits(8);
		return (r[7:0] == MARK_CHAR) ? 8'h41 : r[7:0];
	endfunction

	// random payload with zeros above len
	task automatic build_payload(input int len, output payload_t p);
		p = '0;
		for (int k = 0; k < len; k++) begin
			p[k*8 +: 8] = rand_plain_byte();
		end
	endtask

	task automatic check_val(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			errors++;
			$display("Fail %0s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic finish_test(input string name, input int errs_at_start);
		tests_run++;
		$display("test %0s: %0d errors", name, errors - errs_at_start);
	endtask

	task automatic wait_rx(input int target, input int limit);
		int n;
		n = 0;
		while ((done_cnt + err_cnt) < target && n < limit) begin
			@(posedge sys_clk);
			n++;
		end
		if (n >= limit) begin
			errors++;
			$display("receiver gave no done or error pulse within %0d cycles", limit);
		end
		repeat (SETTLE) @(posedge sys_clk);
	endtask

	task automatic wait_tx_idle(input int limit);
		int n;
		n = 0;
		while (tx_busy && n < limit) begin
			@(posedge sys_clk);
			n++;
		end
		if (n >= limit) begin
			errors++;
			$display("transmitter stayed busy for %0d cycles", limit);
		end
	endtask

	task automatic send_req(input payload_t p, input len_t len);
		@(posedge sys_clk);
		tx_string <= p;
		tx_length <= len;
		tx_req    <= 1'b1;
		@(posedge sys_clk);
		tx_req <= 1'b0;
	endtask

	// 8N1 at BIT_CYCLES per bit with LSB first
	task automatic send_serial(input byte_t b);
		logic [9:0] bits;
		bits = {1'b1, b, 1'b0};
		for (int i = 0; i < 10; i++) begin
			@(posedge sys_clk);
			ser_line <= bits[i];
			repeat (BIT_CYCLES - 1) @(posedge sys_clk);
		end
	endtask

	task automatic send_frame_serial(input payload_t p, input int len);
		send_serial(MARK_CHAR);
		send_serial(MARK_CHAR);
		for (int k = 0; k < len; k++) begin
			send_serial(p[k*8 +: 8]);
		end
		send_serial(MARK_CHAR);
		send_serial(MARK_CHAR);
	endtask

	task automatic run_loopback(input len_t len);
		payload_t p;
		int       base;
		int       done_base;
		build_payload(int'(len), p);
		ref_string = p;
		ref_length = len;
		base = done_cnt + err_cnt;
		done_base = done_cnt;
		send_req(p, len);
		wait_rx(base + 1, FRAME_LIMIT);
		wait_tx_idle(FRAME_LIMIT);
		check_val("rx_done count", done_cnt - done_base, 1);
	endtask

	initial begin
		sys_clk      = 1'b0;
		sys_rst_n    = 1'b0;
		tx_string    = '0;
		tx_length    = '0;
		tx_req       = 1'b0;
		use_loop     = 1'b1;
		ser_line     = 1'b1;
		ref_string   = '0;
		ref_length   = '0;
		expect_error = 1'b0;
		lfsr_state   = 16'd38802;
		errors       = 0;
		tests_run    = 0;
		done_cnt     = 0;
		err_cnt      = 0;
		tx_done_cnt  = 0;
	end

	initial begin
		payload_t p;
		int       e0;
		int       d0;
		int       r0;
		int       t0;
		logic [31:0] r;

		repeat (10) @(posedge sys_clk);
		sys_rst_n <= 1'b1;
		repeat (5) @(posedge sys_clk);

		// full-size frame first, then random lengths
		e0 = errors;
		run_loopback(len_t'(MAX_BYTES));
		for (int i = 0; i < 2; i++) begin
			r = rand_bits(5);
			run_loopback(len_t'(r[4:0]) + len_t'(1));
		end
		finish_test("loopback", e0);

		// second request while busy is dropped
		e0 = errors;
		r = rand_bits(5);
		build_payload(int'(r[4:0]) + 1, p);
		ref_string = p;
		ref_length = len_t'(r[4:0]) + len_t'(1);
		d0 = done_cnt + err_cnt;
		t0 = tx_done_cnt;
		send_req(p, ref_length);
		repeat (5) @(posedge sys_clk);
		tx_req <= 1'b1;
		@(posedge sys_clk);
		tx_req <= 1'b0;
		wait_rx(d0 + 1, FRAME_LIMIT);
		wait_tx_idle(FRAME_LIMIT);
		repeat (FRAME_LIMIT / 4) @(posedge sys_clk);
		check_val("rx_done count", done_cnt + err_cnt - d0, 1);
		check_val("tx_done count", tx_done_cnt - t0, 1);
		finish_test("transmit control", e0);

		e0 = errors;
		run_loopback(len_t'(0));
		finish_test("zero length", e0);

		// line noise, then a lone marker, then a real frame
		e0 = errors;
		@(posedge sys_clk);
		use_loop <= 1'b0;
		d0 = done_cnt;
		r0 = err_cnt;
		for (int i = 0; i < 4; i++) begin
			send_serial(rand_plain_byte());
		end
		send_serial(MARK_CHAR);
		send_serial(8'h78);
		r = rand_bits(5);
		build_payload(int'(r[4:0]) + 1, p);
		ref_string = p;
		ref_length = len_t'(r[4:0]) + len_t'(1);
		send_frame_serial(p, int'(r[4:0]) + 1);
		wait_rx(d0 + r0 + 1, FRAME_LIMIT);
		check_val("rx_done count", done_cnt - d0, 1);
		finish_test("noise ignored", e0);

		// "&&ab&c" leaves the previous frame on the outputs
		e0 = errors;
		expect_error = 1'b1;
		d0 = done_cnt;
		r0 = err_cnt;
		send_serial(MARK_CHAR);
		send_serial(MARK_CHAR);
		send_serial(8'h61);
		send_serial(8'h62);
		send_serial(MARK_CHAR);
		send_serial(8'h63);
		wait_rx(d0 + r0 + 1, FRAME_LIMIT);
		check_val("rx_error count", err_cnt - r0, 1);
		check_val("rx_done count", done_cnt - d0, 0);
		finish_test("malformed close", e0);

		// 33 payload bytes with the error on the last one
		e0 = errors;
		d0 = done_cnt;
		r0 = err_cnt;
		send_serial(MARK_CHAR);
		send_serial(MARK_CHAR);
		for (int i = 0; i < MAX_BYTES; i++) begin
			send_serial(rand_plain_byte());
		end
		repeat (SETTLE) @(posedge sys_clk);
		check_val("rx_error count before byte 33", err_cnt - r0, 0);
		send_serial(rand_plain_byte());
		wait_rx(d0 + r0 + 1, FRAME_LIMIT);
		check_val("rx_error count", err_cnt - r0, 1);
		check_val("rx_done count", done_cnt - d0, 0);
		expect_error = 1'b0;
		finish_test("overflow", e0);

		$display("tests run %0d, checks failed %0d", tests_run, errors);
		if (errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

	// run time budget from six tests of up to 36 bytes each
	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns, run did not finish", WATCHDOG_NS);
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* logic/uart_frame_link.sv */
// UART frame link top level
// frame sender and receiver around an 8N1 serializer and deserializer
`timescale 1ns/1ps
`default_nettype none

module uart_frame_link import uart_frame_pkg::*; #(
	parameter int CLK_DIV = 434
) (
	input  wire           sys_clk,
	input  wire           sys_rst_n,
	input  wire payload_t tx_string,
	input  wire len_t     tx_length,
	input  wire           tx_req,
	output wire           tx_busy,
	output wire           tx_done,
	output wire payload_t rx_string,
	output wire len_t     rx_length,
	output wire           rx_busy,
	output wire           rx_done,
	output wire           rx_error,
	input  wire           uart_rx_port,
	output wire           uart_tx_port
);

	// sender to serializer
	byte_t byte_data;
	logic  byte_req;
	logic  byte_done;

	// deserializer to receiver
	byte_t rx_byte;
	logic  rx_valid;

	frame_tx u_frame_tx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.tx_string (tx_string),
		.tx_length (tx_length),
		.tx_req    (tx_req),
		.byte_done (byte_done),
		.tx_busy   (tx_busy),
		.tx_done   (tx_done),
		.byte_req  (byte_req),
		.byte_data (byte_data)
	);

	uart_tx #(.CLK_DIV(CLK_DIV)) u_uart_tx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.byte_req  (byte_req),
		.byte_data (byte_data),
		.byte_done (byte_done),
		.txd       (uart_tx_port)
	);

	uart_rx #(.CLK_DIV(CLK_DIV)) u_uart_rx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.rxd       (uart_rx_port),
		.rx_byte   (rx_byte),
		.rx_valid  (rx_valid)
	);

	frame_rx u_frame_rx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.rx_byte   (rx_byte),
		.rx_valid  (rx_valid),
		.rx_string (rx_string),
		.rx_length (rx_length),
		.rx_busy   (rx_busy),
		.rx_done   (rx_done),
		.rx_error  (rx_error)
	);

endmodule

`default_nettype wire

/* logic/frame_rx.sv */
// Frame receiver
// hunts for "&&", collects payload up to the closing "&&" and presents
// the string with a done pulse; a broken close or overflow gives rx_error
`timescale 1ns/1ps
`default_nettype none

module frame_rx import uart_frame_pkg::*; (
	input  wire           sys_clk,
	input  wire           sys_rst_n,
	input  wire byte_t    rx_byte,
	input  wire           rx_valid,
	output payload_t      rx_string,
	output len_t          rx_length,
	output logic          rx_busy,
	output logic          rx_done,
	output logic          rx_error
);

	rx_state_e state;
	payload_t  work_buf;
	len_t      work_cnt;
	logic      is_mark;
	logic      buf_full;

	assign is_mark  = (rx_byte == MARK_CHAR);
	assign buf_full = (work_cnt == len_t'(MAX_BYTES));

	// busy between the opening pair and the end of the frame
	assign rx_busy = (state == rx_st_content) || (state == rx_st_close_seen);

	// work buffer is cleared at frame start so unused bytes read as zero
	always_ff @(posedge sys_clk) begin
		if (rx_valid) begin
			if (state == rx_st_open_seen && is_mark) begin
				work_buf <= '0;
			end else if (state == rx_st_content && !is_mark && !buf_full) begin
				work_buf[{work_cnt[4:0], 3'b000} +: 8] <= rx_byte;
			end
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state     <= rx_st_hunt;
			work_cnt  <= '0;
			rx_string <= '0;
			rx_length <= '0;
			rx_done   <= 1'b0;
			rx_error  <= 1'b0;
		end else begin
			rx_done  <= 1'b0;
			rx_error <= 1'b0;

			if (rx_valid) begin
				case (state)
					rx_st_hunt: begin
						// everything but a marker is line noise
						if (is_mark) begin
							state <= rx_st_open_seen;
						end
					end
					rx_st_open_seen: begin
						if (is_mark) begin
							state    <= rx_st_content;
							work_cnt <= '0;
						end else begin
							state <= rx_st_hunt;
						end
					end
					rx_st_content: begin
						if (is_mark) begin
							state <= rx_st_close_seen;
						end else if (buf_full) begin
							// payload too long
							state    <= rx_st_hunt;
							rx_error <= 1'b1;
						end else begin
							work_cnt <= work_cnt + 1'b1;
						end
					end
					default: begin
						state <= rx_st_hunt;
						if (is_mark) begin
							rx_string <= work_buf;
							rx_length <= work_cnt;
							rx_done   <= 1'b1;
						end else begin
							// lone '&' inside the frame
							rx_error <= 1'b1;
						end
					end
				endcase
			end
		end
	end

	// either a done or an error pulse ends a busy frame as busy drops
	a_done_xor_error: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		(rx_done || rx_error) |-> !(rx_done && rx_error) && $past(rx_busy) && !rx_busy);

endmodule

`default_nettype wire

/* logic/frame_tx.sv */
// Frame sender
// wraps a payload in "&&" ... "&&" and feeds it byte by byte to the
// serializer, waiting on byte_done between bytes
`timescale 1ns/1ps
`default_nettype none

module frame_tx import uart_frame_pkg::*; (
	input  wire           sys_clk,
	input  wire           sys_rst_n,
	input  wire payload_t tx_string,
	input  wire len_t     tx_length,
	input  wire           tx_req,
	input  wire           byte_done,
	output logic          tx_busy,
	output logic          tx_done,
	output logic          byte_req,
	output byte_t         byte_data
);

	tx_state_e state;
	len_t      byte_cnt;
	byte_t     cur_byte;

	// payload byte selected by the counter
	assign cur_byte = tx_string[{byte_cnt[4:0], 3'b000} +: 8];

	assign tx_busy = (state != tx_st_idle);
	assign tx_done = (state == tx_st_finish);

	// state names the byte currently in flight
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state     <= tx_st_idle;
			byte_cnt  <= '0;
			byte_req  <= 1'b0;
			byte_data <= '0;
		end else begin
			byte_req <= 1'b0;

			case (state)
				tx_st_idle: begin
					byte_cnt <= '0;
					if (tx_req) begin
						state     <= tx_st_open_1;
						byte_req  <= 1'b1;
						byte_data <= MARK_CHAR;
					end
				end
				tx_st_open_1: begin
					if (byte_done) begin
						state     <= tx_st_open_2;
						byte_req  <= 1'b1;
						byte_data <= MARK_CHAR;
					end
				end
				tx_st_open_2: begin
					if (byte_done) begin
						byte_req <= 1'b1;
						// empty payload goes straight to the closing pair
						if (tx_length == '0) begin
							state     <= tx_st_close_1;
							byte_data <= MARK_CHAR;
						end else begin
							state     <= tx_st_content;
							byte_data <= cur_byte;
							byte_cnt  <= byte_cnt + 1'b1;
						end
					end
				end
				tx_st_content: begin
					if (byte_done) begin
						byte_req <= 1'b1;
						if (byte_cnt == tx_length) begin
							state     <= tx_st_close_1;
							byte_data <= MARK_CHAR;
						end else begin
							byte_data <= cur_byte;
							byte_cnt  <= byte_cnt + 1'b1;
						end
					end
				end
				tx_st_close_1: begin
					if (byte_done) begin
						state     <= tx_st_close_2;
						byte_req  <= 1'b1;
						byte_data <= MARK_CHAR;
					end
				end
				tx_st_close_2: begin
					if (byte_done) begin
						state <= tx_st_finish;
					end
				end
				default: begin
					state <= tx_st_idle;
				end
			endcase
		end
	end

	// one-cycle done, only after the last marker has left the line
	a_done_after_close: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		tx_done |-> ($past(state) == tx_st_close_2) ##1 !tx_done);

endmodule

`default_nettype wire

/* logic/uart_rx.sv */
// UART byte deserializer
// 8N1, LSB first; synchronizes the line, rejects short start glitches,
// samples mid-bit and strobes rx_valid in the middle of a good stop bit
`timescale 1ns/1ps
`default_nettype none

module uart_rx import uart_frame_pkg::*; #(
	parameter int CLK_DIV = 434
) (
	input  wire   sys_clk,
	input  wire   sys_rst_n,
	input  wire   rxd,
	output byte_t rx_byte,
	output logic  rx_valid
);

	localparam int CNT_W = $clog2(CLK_DIV + 1);

	bit_state_e       state;
	logic [CNT_W-1:0] baud_cnt;
	logic [2:0]       bit_idx;
	byte_t            shift_reg;
	logic             rxd_meta;
	logic             rxd_sync;
	logic             rxd_last;
	logic             start_fall;
	logic             half_end;
	logic             baud_end;

	assign start_fall = rxd_last & ~rxd_sync;
	assign half_end   = (baud_cnt == CNT_W'(CLK_DIV / 2 - 1));
	assign baud_end   = (baud_cnt == CNT_W'(CLK_DIV - 1));

	// two-flop synchronizer plus edge history, line idles high
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rxd_meta <= 1'b1;
			rxd_sync <= 1'b1;
			rxd_last <= 1'b1;
		end else begin
			rxd_meta <= rxd;
			rxd_sync <= rxd_meta;
			rxd_last <= rxd_sync;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state     <= bit_st_idle;
			baud_cnt  <= '0;
			bit_idx   <= '0;
			shift_reg <= '0;
			rx_byte   <= '0;
			rx_valid  <= 1'b0;
		end else begin
			rx_valid <= 1'b0;
			baud_cnt <= baud_cnt + 1'b1;

			case (state)
				bit_st_idle: begin
					baud_cnt <= '0;
					if (start_fall) begin
						state <= bit_st_start;
					end
				end
				bit_st_start: begin
					// still low at half a bit, otherwise a glitch
					if (half_end) begin
						baud_cnt <= '0;
						bit_idx  <= '0;
						state    <= rxd_sync ? bit_st_idle : bit_st_data;
					end
				end
				bit_st_data: begin
					if (baud_end) begin
						baud_cnt  <= '0;
						shift_reg <= {rxd_sync, shift_reg[7:1]};
						bit_idx   <= bit_idx + 1'b1;
						if (bit_idx == 3'd7) begin
							state <= bit_st_stop;
						end
					end
				end
				default: begin
					// mid stop bit; framing error drops the byte
					if (baud_end) begin
						state <= bit_st_idle;
						if (rxd_sync) begin
							rx_byte  <= shift_reg;
							rx_valid <= 1'b1;
						end
					end
				end
			endcase
		end
	end

	a_valid_single: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		rx_valid |=> !rx_valid);

endmodule

`default_nettype wire

/* logic/uart_tx.sv */
// UART byte serializer
// 8N1, LSB first; start bit goes out the cycle after byte_req,
// byte_done pulses once the stop bit has finished
`timescale 1ns/1ps
`default_nettype none

module uart_tx import uart_frame_pkg::*; #(
	parameter int CLK_DIV = 434
) (
	input  wire        sys_clk,
	input  wire        sys_rst_n,
	input  wire        byte_req,
	input  wire byte_t byte_data,
	output logic       byte_done,
	output logic       txd
);

	localparam int CNT_W = $clog2(CLK_DIV + 1);

	bit_state_e       state;
	logic [CNT_W-1:0] baud_cnt;
	logic [2:0]       bit_idx;
	byte_t            shift_reg;
	logic             baud_end;

	// last cycle of the current bit
	assign baud_end = (baud_cnt == CNT_W'(CLK_DIV - 1));

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state     <= bit_st_idle;
			baud_cnt  <= '0;
			bit_idx   <= '0;
			shift_reg <= '0;
			txd       <= 1'b1;
			byte_done <= 1'b0;
		end else begin
			byte_done <= 1'b0;

			// bit timer runs whenever a byte is on the line
			if (state == bit_st_idle || baud_end) begin
				baud_cnt <= '0;
			end else begin
				baud_cnt <= baud_cnt + 1'b1;
			end

			case (state)
				bit_st_idle: begin
					if (byte_req) begin
						state     <= bit_st_start;
						shift_reg <= byte_data;
						txd       <= 1'b0;
					end
				end
				bit_st_start: begin
					if (baud_end) begin
						state     <= bit_st_data;
						bit_idx   <= '0;
						txd       <= shift_reg[0];
						shift_reg <= shift_reg >> 1;
					end
				end
				bit_st_data: begin
					if (baud_end) begin
						if (bit_idx == 3'd7) begin
							state <= bit_st_stop;
							txd   <= 1'b1;
						end else begin
							bit_idx   <= bit_idx + 1'b1;
							txd       <= shift_reg[0];
							shift_reg <= shift_reg >> 1;
						end
					end
				end
				default: begin
					// stop bit
					if (baud_end) begin
						state     <= bit_st_idle;
						byte_done <= 1'b1;
					end
				end
			endcase
		end
	end

	// the frame sender must wait for byte_done before the next request
	a_req_when_idle: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		byte_req |-> state == bit_st_idle);

endmodule

`default_nettype wire

/* logic/uart_frame_pkg.sv */
// UART frame link shared definitions
// frame markers, payload sizing, width types and the FSM state encodings
`default_nettype none

package uart_frame_pkg;

	// largest payload in bytes; string port widths follow from it
	localparam int MAX_BYTES = 32;
	localparam int LEN_W     = $clog2(MAX_BYTES + 1);
	localparam int PAYLOAD_W = MAX_BYTES * 8;

	// one UART character
	typedef logic [7:0] byte_t;

	// payload length, 0 to MAX_BYTES
	typedef logic [LEN_W-1:0] len_t;

	// byte k sits in bits 8k+7 down to 8k
	typedef logic [PAYLOAD_W-1:0] payload_t;

	// frame marker '&'
	localparam byte_t MARK_CHAR = 8'h26;

	// frame sender, one state per byte in flight
	typedef enum logic [2:0] {
		tx_st_idle,
		tx_st_open_1,
		tx_st_open_2,
		tx_st_content,
		tx_st_close_1,
		tx_st_close_2,
		tx_st_finish
	} tx_state_e;

	// frame receiver
	typedef enum logic [1:0] {
		rx_st_hunt,
		rx_st_open_seen,
		rx_st_content,
		rx_st_close_seen
	} rx_state_e;

	// serializer and deserializer bit phases
	typedef enum logic [1:0] {
		bit_st_idle,
		bit_st_start,
		bit_st_data,
		bit_st_stop
	} bit_state_e;

endpackage

`default_nettype wire
